// File: cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_W = 32;
    localparam int PC_W   = 11;  // instruction and data memory address width
    localparam int REG_AW = 4;

    typedef enum logic [3:0] {
        OP_MOV = 4'h0,
        OP_ADD = 4'h1,
        OP_SUB = 4'h2,
        OP_AND = 4'h3,
        OP_ORR = 4'h4,
        OP_CMP = 4'h5,
        OP_LDR = 4'h6,
        OP_STR = 4'h7,
        OP_B   = 4'h8
    } op_e;

    // ARM condition encodings without HI/LS
    typedef enum logic [3:0] {
        C_EQ = 4'h0,
        C_NE = 4'h1,
        C_CS = 4'h2,
        C_CC = 4'h3,
        C_MI = 4'h4,
        C_PL = 4'h5,
        C_VS = 4'h6,
        C_VC = 4'h7,
        C_GE = 4'ha,
        C_LT = 4'hb,
        C_GT = 4'hc,
        C_LE = 4'hd,
        C_AL = 4'he
    } cond_e;

    typedef enum logic [1:0] {SH_LSL, SH_LSR, SH_ASR, SH_ROR} shift_e;

    typedef enum logic [2:0] {ALU_PASS_B, ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR} alu_op_e;

    typedef enum logic [2:0] {S_LOAD_PC, S_FETCH, S_EXECUTE, S_MEMORY, S_WRITEBACK} state_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // bits 13:2 double as imm12 and bits 21:0 as the branch offset
    typedef struct packed {
        cond_e             cond;
        op_e               op;
        logic              imm_sel;
        logic              set_flags;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rn;
        logic [REG_AW-1:0] rm;
        shift_e            shift;
        logic [4:0]        shamt;
        logic [2:0]        spare;
    } instr_t;

    typedef struct packed {
        logic [REG_AW-1:0] rn;
        logic [REG_AW-1:0] rm;
        logic [REG_AW-1:0] rd;
        shift_e            shift;
        logic [4:0]        shamt;
        logic              imm_sel;
        logic [11:0]       imm12;
        logic [PC_W-1:0]   branch_off;  // word offset that wraps in PC_W bits
        alu_op_e           alu_op;
        logic              load_pc;
        logic              pc_inc;
        logic              pc_branch;
        logic              en_ab;
        logic              en_result;
        logic              en_status;
        logic              reg_we;
        logic              wb_from_mem;
    } ctrl_t;

endpackage : cpu_pkg

// File: regfile.sv
module regfile import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              we,
    input  logic [REG_AW-1:0] w_addr,
    input  logic [DATA_W-1:0] w_data,
    input  logic [REG_AW-1:0] a_addr,
    input  logic [REG_AW-1:0] b_addr,
    input  logic [REG_AW-1:0] s_addr,
    input  logic [REG_AW-1:0] dbg_addr,
    output logic [DATA_W-1:0] a_data,
    output logic [DATA_W-1:0] b_data,
    output logic [DATA_W-1:0] s_data,
    output logic [DATA_W-1:0] dbg_data
);

    logic [DATA_W-1:0] regs [2**REG_AW];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[w_addr] <= w_data;
        end
    end

    assign a_data   = regs[a_addr];   // operand A
    assign b_data   = regs[b_addr];   // unshifted Rm
    assign s_data   = regs[s_addr];   // store data for STR
    assign dbg_data = regs[dbg_addr];

    // decode of rd must be clean by the time writeback fires
    a_waddr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> !$isunknown(w_addr)
    );

endmodule : regfile

// File: alu.sv
module alu import cpu_pkg::*; (
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b_reg,
    input  logic              imm_sel,
    input  logic [11:0]       imm12,
    input  shift_e            shift,
    input  logic [4:0]        shamt,
    input  alu_op_e           alu_op,
    input  logic              carry_in,
    output logic [DATA_W-1:0] result,
    output flags_t            flags
);

    logic [DATA_W-1:0] b_op;
    logic              sh_carry;
    logic [DATA_W:0]   sum;
    logic [DATA_W:0]   diff;
    logic              c_out;
    logic              v_out;

    // barrel shifter where a zero shamt passes Rm and the old carry through
    always_comb begin
        b_op     = b_reg;
        sh_carry = carry_in;
        if (imm_sel) begin
            b_op = {{(DATA_W-12){1'b0}}, imm12};
        end else if (shamt != 5'd0) begin
            case (shift)
                SH_LSL:  {sh_carry, b_op} = {1'b0, b_reg} << shamt;
                SH_LSR:  {b_op, sh_carry} = {b_reg, 1'b0} >> shamt;
                SH_ASR:  {b_op, sh_carry} = $signed({b_reg, 1'b0}) >>> shamt;
                default: begin
                    b_op     = (b_reg >> shamt) | (b_reg << (DATA_W - shamt));
                    sh_carry = b_op[DATA_W-1];  // last bit rotated out
                end
            endcase
        end
    end

    assign sum  = {1'b0, a} + {1'b0, b_op};
    assign diff = {1'b0, a} + {1'b0, ~b_op} + 1'b1;  // carry set means no borrow

    always_comb begin
        result = b_op;
        c_out  = sh_carry;
        v_out  = 1'b0;  // datapath keeps the old V for logic ops
        case (alu_op)
            ALU_ADD: begin
                result = sum[DATA_W-1:0];
                c_out  = sum[DATA_W];
                v_out  = (a[DATA_W-1] == b_op[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
            end
            ALU_SUB: begin
                result = diff[DATA_W-1:0];
                c_out  = diff[DATA_W];
                v_out  = (a[DATA_W-1] != b_op[DATA_W-1]) && (diff[DATA_W-1] != a[DATA_W-1]);
            end
            ALU_AND: result = a & b_op;
            ALU_ORR: result = a | b_op;
            default: result = b_op;  // MOV
        endcase
    end

    assign flags = '{n: result[DATA_W-1], z: (result == '0), c: c_out, v: v_out};

endmodule : alu

// File: datapath.sv
module datapath import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  ctrl_t             ctrl,
    input  logic [PC_W-1:0]   start_pc,
    input  logic [DATA_W-1:0] ram_data2,
    input  logic [REG_AW-1:0] reg_addr,
    output logic [PC_W-1:0]   pc,
    output logic [PC_W-1:0]   ram_addr2,
    output logic [DATA_W-1:0] ram_in2,
    output flags_t            status,
    output logic [DATA_W-1:0] dp_out,
    output logic [DATA_W-1:0] reg_output
);

    logic [PC_W-1:0]   pc_q;
    logic [DATA_W-1:0] a_q, b_q;
    logic [DATA_W-1:0] result_q;
    flags_t            status_q;
    logic [DATA_W-1:0] rn_data, rm_data;
    logic [DATA_W-1:0] alu_result;
    flags_t            alu_flags;
    logic [DATA_W-1:0] wb_data;
    logic              arith;

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (ctrl.reg_we),
        .w_addr   (ctrl.rd),
        .w_data   (wb_data),
        .a_addr   (ctrl.rn),
        .b_addr   (ctrl.rm),
        .s_addr   (ctrl.rd),
        .dbg_addr (reg_addr),
        .a_data   (rn_data),
        .b_data   (rm_data),
        .s_data   (ram_in2),
        .dbg_data (reg_output)
    );

    alu u_alu (
        .a        (a_q),
        .b_reg    (b_q),
        .imm_sel  (ctrl.imm_sel),
        .imm12    (ctrl.imm12),
        .shift    (ctrl.shift),
        .shamt    (ctrl.shamt),
        .alu_op   (ctrl.alu_op),
        .carry_in (status_q.c),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    assign arith = (ctrl.alu_op == ALU_ADD) || (ctrl.alu_op == ALU_SUB);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q     <= '0;
            result_q <= '0;
            status_q <= '0;
        end else begin
            if (ctrl.load_pc)        pc_q <= start_pc;
            else if (ctrl.pc_branch) pc_q <= pc_q + 1'b1 + ctrl.branch_off;
            else if (ctrl.pc_inc)    pc_q <= pc_q + 1'b1;
            if (ctrl.en_result) result_q <= alu_result;
            if (ctrl.en_status) begin
                status_q.n <= alu_flags.n;
                status_q.z <= alu_flags.z;
                status_q.c <= alu_flags.c;
                status_q.v <= arith ? alu_flags.v : status_q.v;  // logic ops keep V
            end
        end
    end

    // operand latches with the shift applied later inside the ALU
    always_ff @(posedge clk) begin
        if (ctrl.en_ab) begin
            a_q <= rn_data;
            b_q <= rm_data;
        end
    end

    assign wb_data   = ctrl.wb_from_mem ? ram_data2 : result_q;
    assign pc        = pc_q;
    assign ram_addr2 = result_q[PC_W-1:0];
    assign status    = status_q;
    assign dp_out    = result_q;

    a_pc_src_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl.load_pc, ctrl.pc_inc, ctrl.pc_branch})
    );

endmodule : datapath

// File: controller.sv
module controller import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  instr_t instr,
    input  flags_t status,
    output ctrl_t  ctrl,
    output logic   mem_w_en
);

    state_e        state_q, state_d;
    instr_t        ir_q;
    logic [31:0]   ir_bits;
    logic          pass_q;
    logic          cond_pass;
    logic          is_mem;
    logic          writes_reg;
    logic          sets_flags;
    logic          take_branch;

    function automatic logic cond_ok(cond_e c, flags_t f);
        case (c)
            C_EQ:    return f.z;
            C_NE:    return !f.z;
            C_CS:    return f.c;
            C_CC:    return !f.c;
            C_MI:    return f.n;
            C_PL:    return !f.n;
            C_VS:    return f.v;
            C_VC:    return !f.v;
            C_GE:    return f.n == f.v;
            C_LT:    return f.n != f.v;
            C_GT:    return !f.z && (f.n == f.v);
            C_LE:    return f.z || (f.n != f.v);
            C_AL:    return 1'b1;
            default: return 1'b0;  // unsupported codes never execute
        endcase
    endfunction

    always_comb begin
        case (state_q)
            S_LOAD_PC:   state_d = S_FETCH;
            S_FETCH:     state_d = S_EXECUTE;
            S_EXECUTE:   state_d = S_MEMORY;
            S_MEMORY:    state_d = S_WRITEBACK;
            default:     state_d = S_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_LOAD_PC;
            ir_q    <= '0;
            pass_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_FETCH)   ir_q   <= instr;
            if (state_q == S_EXECUTE) pass_q <= cond_pass;  // flags may change in MEMORY
        end
    end

    assign ir_bits     = ir_q;
    assign cond_pass   = cond_ok(ir_q.cond, status);
    assign is_mem      = (ir_q.op == OP_LDR) || (ir_q.op == OP_STR);
    assign writes_reg  = ir_q.op inside {OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_LDR};
    assign sets_flags  = (ir_q.op == OP_CMP) ||
                         (ir_q.set_flags && ir_q.op inside {OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_ORR});
    assign take_branch = pass_q && (ir_q.op == OP_B);

    // decode with fields straight from the instruction register
    always_comb begin
        ctrl            = '0;
        ctrl.rn         = ir_q.rn;
        ctrl.rm         = ir_q.rm;
        ctrl.rd         = ir_q.rd;
        ctrl.shift      = ir_q.shift;
        ctrl.shamt      = ir_q.shamt;
        ctrl.imm_sel    = ir_q.imm_sel || is_mem;  // base plus imm12 only
        ctrl.imm12      = ir_bits[13:2];
        ctrl.branch_off = ir_bits[PC_W-1:0];
        case (ir_q.op)
            OP_ADD, OP_LDR, OP_STR: ctrl.alu_op = ALU_ADD;
            OP_SUB, OP_CMP:         ctrl.alu_op = ALU_SUB;
            OP_AND:                 ctrl.alu_op = ALU_AND;
            OP_ORR:                 ctrl.alu_op = ALU_ORR;
            default:                ctrl.alu_op = ALU_PASS_B;
        endcase
        ctrl.load_pc     = (state_q == S_LOAD_PC);
        ctrl.en_ab       = (state_q == S_EXECUTE) && cond_pass;
        ctrl.en_result   = (state_q == S_MEMORY) && pass_q;
        ctrl.en_status   = (state_q == S_MEMORY) && pass_q && sets_flags;
        ctrl.reg_we      = (state_q == S_WRITEBACK) && pass_q && writes_reg;
        ctrl.wb_from_mem = (ir_q.op == OP_LDR);
        ctrl.pc_branch   = (state_q == S_WRITEBACK) && take_branch;
        ctrl.pc_inc      = (state_q == S_WRITEBACK) && !take_branch;
    end

    // address register was filled in MEMORY, so the store goes out here
    assign mem_w_en = (state_q == S_WRITEBACK) && pass_q && (ir_q.op == OP_STR);

    a_store_after_addr: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_w_en |-> $past(ctrl.en_result) && !$past(mem_w_en)
    );

    a_we_in_writeback: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctrl.reg_we |-> $past(state_q == S_MEMORY) && $past(pass_q)
    );

endmodule : controller

// File: cpu.sv
module cpu import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  instr_t            instr,
    input  logic [DATA_W-1:0] ram_data2,
    input  logic [PC_W-1:0]   start_pc,
    input  logic [REG_AW-1:0] reg_addr,
    output logic              mem_w_en,
    output logic [PC_W-1:0]   ram_addr2,
    output logic [DATA_W-1:0] ram_in2,
    output flags_t            status,
    output logic [DATA_W-1:0] dp_out,
    output logic [PC_W-1:0]   pc,
    output logic [DATA_W-1:0] reg_output  // debug read of reg_addr
);

    ctrl_t ctrl;

    datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .start_pc   (start_pc),
        .ram_data2  (ram_data2),
        .reg_addr   (reg_addr),
        .pc         (pc),
        .ram_addr2  (ram_addr2),
        .ram_in2    (ram_in2),
        .status     (status),
        .dp_out     (dp_out),
        .reg_output (reg_output)
    );

    // flags go back for condition tests
    controller u_controller (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .status   (status),
        .ctrl     (ctrl),
        .mem_w_en (mem_w_en)
    );

endmodule : cpu

// File: tb_cpu.sv
module tb_cpu import cpu_pkg::*; ();

    typedef enum logic [1:0] {K_REG, K_FLAGS, K_STORE, K_BRANCH} kind_e;

    // expected outcome of one executed instruction
    typedef struct packed {
        kind_e             kind;
        logic [REG_AW-1:0] reg_idx;  // read back through the debug port
        logic [DATA_W-1:0] reg_val;
        logic [DATA_W-1:0] res_val;
        logic [PC_W-1:0]   next_pc;
        logic [PC_W-1:0]   st_addr;
        flags_t            flags;
    } step_t;

    logic              clk;
    logic              rst_n;
    instr_t            instr;
    logic [DATA_W-1:0] ram_data2;
    logic [PC_W-1:0]   start_pc;
    logic [REG_AW-1:0] reg_addr;
    logic              mem_w_en;
    logic [PC_W-1:0]   ram_addr2;
    logic [DATA_W-1:0] ram_in2;
    flags_t            status;
    logic [DATA_W-1:0] dp_out;
    logic [PC_W-1:0]   pc;
    logic [DATA_W-1:0] reg_output;

    logic [DATA_W-1:0] rom [2**PC_W];
    logic [DATA_W-1:0] ram [2**PC_W];
    logic [DATA_W-1:0] smem [2**PC_W];  // shadow data memory
    logic [DATA_W-1:0] sregs [16];
    logic [DATA_W-1:0] sres;  // shadow result register
    flags_t            sflags;
    logic [PC_W-1:0]   spc;
    step_t             steps [64];
    int                n_steps;
    int                checks_planned;
    int                checks_done;
    int                retired;
    int                cycles = 0;
    int                cycle_limit = 1000;
    logic              store_window;
    logic [31:0]       seed;

    cpu dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .ram_data2  (ram_data2),
        .start_pc   (start_pc),
        .reg_addr   (reg_addr),
        .mem_w_en   (mem_w_en),
        .ram_addr2  (ram_addr2),
        .ram_in2    (ram_in2),
        .status     (status),
        .dp_out     (dp_out),
        .pc         (pc),
        .reg_output (reg_output)
    );

    assign instr     = instr_t'(rom[pc]);
    assign ram_data2 = ram[ram_addr2];  // combinational read

    always @(posedge clk) begin
        if (mem_w_en) ram[ram_addr2] <= ram_in2;
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
        checks_done++;
        assert (got === exp)
            else abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit)
            abort_run($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
    end

    a_no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !mem_w_en)
        else abort_run("mem_w_en was raised while reset was active");

    // strobe must line up with the expected store cycle and nowhere else
    a_store_window: assert property (
        @(posedge clk) disable iff (!rst_n) mem_w_en == store_window
    ) else abort_run("mem_w_en strobe did not match the expected store cycle");

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] fill_word(logic [PC_W-1:0] a);
        return {a, a[9:0], a} ^ 32'h5a3c_0f96;
    endfunction

    function automatic logic [31:0] shifted(logic [31:0] v, shift_e sh, logic [4:0] n);
        case (sh)
            SH_LSL:  return v << n;
            SH_LSR:  return v >> n;
            SH_ASR:  return $signed(v) >>> n;
            default: return (n == 0) ? v : ((v >> n) | (v << (32 - n)));
        endcase
    endfunction

    function automatic logic cond_holds(cond_e c, flags_t f);
        case (c)
            C_EQ:    return f.z;
            C_NE:    return !f.z;
            C_GE:    return f.n == f.v;
            C_LT:    return f.n != f.v;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] enc_reg(cond_e c, op_e op, logic [3:0] rd, logic [3:0] rn,
                                            logic [3:0] rm, shift_e sh, logic [4:0] n);
        return {c, op, 2'b00, rd, rn, rm, sh, n, 3'b000};
    endfunction

    function automatic logic [31:0] enc_imm(cond_e c, op_e op, logic [3:0] rd, logic [3:0] rn,
                                            logic [11:0] imm);
        return {c, op, 2'b10, rd, rn, imm, 2'b00};
    endfunction

    task automatic add_step(logic [31:0] word, kind_e k, logic [3:0] rd,
                            logic [PC_W-1:0] next_pc, logic [PC_W-1:0] addr);
        rom[spc] = word;
        steps[n_steps] = '{kind: k, reg_idx: rd, reg_val: sregs[rd], res_val: sres,
                           next_pc: next_pc, st_addr: addr, flags: sflags};
        n_steps++;
        checks_planned += 2 + ((k != K_BRANCH) ? 1 : 0);
        checks_planned += ((k == K_FLAGS) ? 1 : 0) + ((k == K_STORE) ? 3 : 0);
        spc = next_pc;
    endtask

    task automatic alu_instr(cond_e c, op_e op, logic [3:0] rd, logic [3:0] rn, logic use_imm,
                             logic [11:0] imm, logic [3:0] rm, shift_e sh, logic [4:0] n);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        a = sregs[rn];
        b = use_imm ? {20'd0, imm} : shifted(sregs[rm], sh, n);
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_ORR:  r = a | b;
            default: r = b;
        endcase
        if (cond_holds(c, sflags)) begin
            sregs[rd] = r;  // failed condition is a no-op
            sres = r;
        end
        add_step(use_imm ? enc_imm(c, op, rd, rn, imm) : enc_reg(c, op, rd, rn, rm, sh, n),
                 K_REG, rd, spc + 1'b1, '0);
    endtask

    task automatic cmp_instr(logic [3:0] rn, logic [11:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        a = sregs[rn];
        b = {20'd0, imm};
        r = a - b;
        sres = r;
        sflags.n = r[31];
        sflags.z = (r == 0);
        sflags.c = (a >= b);  // carry means no borrow
        sflags.v = (a[31] != b[31]) && (r[31] != a[31]);
        add_step(enc_imm(C_AL, OP_CMP, 4'd0, rn, imm), K_FLAGS, rn, spc + 1'b1, '0);
    endtask

    task automatic mem_instr(op_e op, logic [3:0] rd, logic [3:0] rn, logic [11:0] imm);
        logic [31:0]     ea;
        logic [PC_W-1:0] addr;
        kind_e           k;
        ea = sregs[rn] + {20'd0, imm};
        addr = ea[PC_W-1:0];
        sres = ea;
        if (op == OP_STR) begin
            smem[addr] = sregs[rd];
            k = K_STORE;
        end else begin
            sregs[rd] = smem[addr];
            k = K_REG;
        end
        add_step(enc_imm(C_AL, op, rd, rn, imm), k, rd, spc + 1'b1, addr);
    endtask

    task automatic branch_instr(cond_e c, logic [21:0] off, logic [3:0] chk_rd);
        logic [PC_W-1:0] target;
        target = spc + 1'b1;
        if (cond_holds(c, sflags)) begin
            for (int i = 1; i <= off; i++) begin
                rom[spc + i] = enc_imm(C_AL, OP_MOV, chk_rd, 4'd0, 12'hfff);  // jumped over
            end
            target = spc + 1'b1 + off[PC_W-1:0];
        end
        add_step({c, OP_B, 2'b00, off}, K_BRANCH, chk_rd, target, '0);
    endtask

    task automatic build_program();
        cond_e       conds [4];
        op_e         ops [5];
        cond_e       nc;
        logic [31:0] r;
        logic [31:0] q;
        logic [11:0] x;
        conds = '{C_EQ, C_NE, C_GE, C_LT};
        ops = '{OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_ORR};
        for (int a = 0; a < 2**PC_W; a++) begin
            rom[a] = '0;
            ram[a] = fill_word(a[PC_W-1:0]);
            smem[a] = ram[a];
        end
        for (int i = 0; i < 16; i++) sregs[i] = '0;
        sflags = '0;
        sres = '0;
        spc = start_pc;
        n_steps = 0;
        checks_planned = 1;
        for (int i = 1; i <= 8; i++) begin
            r = next_rand();
            alu_instr(C_AL, OP_MOV, i[3:0], 4'd0, 1'b1, r[31:20], 4'd0, SH_LSL, 5'd0);
        end
        // random data processing on r1..r8
        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            q = next_rand();
            alu_instr(C_AL, ops[r[31:29] % 5], 4'd1 + r[28:26], r[25:22] % 9, r[17],
                      q[31:20], r[21:18] % 9, shift_e'(r[16:15]), r[14:10]);
        end
        // compare then a conditional add on r10
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            x = (i < 2) ? r[31:20] : r[19:8];
            alu_instr(C_AL, OP_MOV, 4'd9, 4'd0, 1'b1, r[31:20], 4'd0, SH_LSL, 5'd0);
            cmp_instr(4'd9, x);
            alu_instr(conds[i], OP_ADD, 4'd10, 4'd10, 1'b1, 12'd1, 4'd0, SH_LSL, 5'd0);
        end
        r = next_rand();
        q = next_rand();
        alu_instr(C_AL, OP_MOV, 4'd11, 4'd0, 1'b1, {2'b00, r[31:22]}, 4'd0, SH_LSL, 5'd0);
        mem_instr(OP_STR, 4'd3, 4'd11, q[31:20]);
        mem_instr(OP_LDR, 4'd12, 4'd11, q[31:20]);
        mem_instr(OP_STR, 4'd5, 4'd11, q[19:8]);
        mem_instr(OP_LDR, 4'd15, 4'd11, q[19:8]);
        branch_instr(C_AL, 22'd1, 4'd13);
        if (sflags.z) nc = C_NE;
        else nc = C_EQ;
        branch_instr(nc, 22'd3, 4'd13);  // falls through
        r = next_rand();
        alu_instr(C_AL, OP_MOV, 4'd14, 4'd0, 1'b1, r[31:20], 4'd0, SH_LSL, 5'd0);
        cycle_limit = 8 + 1 + 4 * n_steps + 20;
    endtask

    initial begin
        rst_n = 1'b0;
        start_pc = 11'd16;
        reg_addr = '0;
        store_window = 1'b0;
        seed = 32'h511f_188b;
        checks_done = 0;
        retired = 0;
        build_program();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);  // load cycle
        check_eq("pc", pc, start_pc);
        while (retired < n_steps) begin
            reg_addr = steps[retired].reg_idx;
            repeat (3) @(negedge clk);  // now in writeback
            if (steps[retired].kind == K_STORE) begin
                store_window = 1'b1;
                check_eq("mem_w_en", mem_w_en, 1'b1);
                check_eq("ram_addr2", ram_addr2, steps[retired].st_addr);
                check_eq("ram_in2", ram_in2, steps[retired].reg_val);
            end
            @(negedge clk);
            store_window = 1'b0;
            check_eq("pc", pc, steps[retired].next_pc);
            check_eq($sformatf("reg_output r%0d", steps[retired].reg_idx), reg_output,
                     steps[retired].reg_val);
            if (steps[retired].kind != K_BRANCH)
                check_eq("dp_out", dp_out, steps[retired].res_val);
            if (steps[retired].kind == K_FLAGS) check_eq("status", status, steps[retired].flags);
            retired++;
        end
        if (checks_done == checks_planned) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run("not every planned check was reached");
        end
    end

endmodule : tb_cpu

// File: cpu.f
cpu_pkg.sv
regfile.sv
alu.sv
datapath.sv
controller.sv
cpu.sv
tb_cpu.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - regfile.sv
  - alu.sv
  - datapath.sv
  - controller.sv
  - cpu.sv
  - target: simulation
    files:
      - tb_cpu.sv
